// ==== src/la32_macros.svh ====
`ifndef LA32_MACROS_SVH
`define LA32_MACROS_SVH

// Fixed architectural constants of the LA32R core.

// Address of the first instruction fetched after reset.
`define LA32_RESET_PC 32'h1c00_0000

// Width of data words, addresses and instruction words.
`define LA32_XLEN 32

// Number of general purpose registers, r0 included.
`define LA32_NUM_REGS 32

// Width of a register number.
`define LA32_REG_BITS 5

`endif

// ==== src/la32_pkg.sv ====
`include "la32_macros.svh"

package la32_pkg;

    typedef logic [`LA32_XLEN-1:0] word_t;
    typedef logic [`LA32_REG_BITS-1:0] reg_num_t;

    // Operations performed by the ALU in EXECUTE.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11  // Passes src2 through.
    } alu_op_t;

    // Control transfer kind, resolved in DECODE.
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_B    = 3'd3,
        BR_BL   = 3'd4,
        BR_JIRL = 3'd5
    } branch_kind_t;

    // States of the multicycle sequencer.
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } stage_t;

    // Everything the later stages need to know about one instruction.
    typedef struct packed {
        alu_op_t      alu_op;
        branch_kind_t branch;
        word_t        imm;         // Already extended or shifted.
        word_t        br_off;      // Byte offset of the branch target.
        logic         src1_is_pc;
        logic         src2_is_imm;
        logic         src2_is_rd;  // Second read port reads rd.
        logic         mem_write;
        logic         mem_read;
        logic         reg_write;
        reg_num_t     dest;
        reg_num_t     rj;
        reg_num_t     rk_or_rd;
    } decode_t;

endpackage

// ==== src/la32_decoder.sv ====
`timescale 1ns/1ps

module la32_decoder (
    input  la32_pkg::word_t   inst,
    output la32_pkg::decode_t dec
);

    la32_pkg::reg_num_t rd;
    la32_pkg::reg_num_t rj;
    la32_pkg::reg_num_t rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        need_si20;
    logic        need_si26;
    logic        src2_is_4;
    logic        known;

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};  // Offset high bits sit in the low field.

    always_comb begin
        dec       = '0;
        need_si20 = 1'b0;
        need_si26 = 1'b0;
        src2_is_4 = 1'b0;
        known     = 1'b1;

        // Pattern is opcode fields 31:26, 25:22, 21:20 and 19:15.
        casez (inst[31:15])
            17'b000000_0000_01_00000: dec.alu_op = la32_pkg::ALU_ADD;
            17'b000000_0000_01_00010: dec.alu_op = la32_pkg::ALU_SUB;
            17'b000000_0000_01_00100: dec.alu_op = la32_pkg::ALU_SLT;
            17'b000000_0000_01_00101: dec.alu_op = la32_pkg::ALU_SLTU;
            17'b000000_0000_01_01000: dec.alu_op = la32_pkg::ALU_NOR;
            17'b000000_0000_01_01001: dec.alu_op = la32_pkg::ALU_AND;
            17'b000000_0000_01_01010: dec.alu_op = la32_pkg::ALU_OR;
            17'b000000_0000_01_01011: dec.alu_op = la32_pkg::ALU_XOR;
            17'b000000_0001_00_00001: dec.alu_op = la32_pkg::ALU_SLL;
            17'b000000_0001_00_01001: dec.alu_op = la32_pkg::ALU_SRL;
            17'b000000_0001_00_10001: dec.alu_op = la32_pkg::ALU_SRA;
            17'b000000_1010_??_?????: dec.alu_op = la32_pkg::ALU_ADD;
            17'b000101_0???_??_?????: begin
                dec.alu_op = la32_pkg::ALU_LUI;
                need_si20  = 1'b1;
            end
            17'b001010_0010_??_?????: dec.mem_read  = 1'b1;
            17'b001010_0110_??_?????: dec.mem_write = 1'b1;
            17'b010011_????_??_?????: begin
                dec.branch = la32_pkg::BR_JIRL;
                src2_is_4  = 1'b1;
            end
            17'b010100_????_??_?????: begin
                dec.branch = la32_pkg::BR_B;
                need_si26  = 1'b1;
            end
            17'b010101_????_??_?????: begin
                dec.branch = la32_pkg::BR_BL;
                need_si26  = 1'b1;
                src2_is_4  = 1'b1;
            end
            17'b010110_????_??_?????: dec.branch = la32_pkg::BR_BEQ;
            17'b010111_????_??_?????: dec.branch = la32_pkg::BR_BNE;
            default: known = 1'b0;  // Unknown words act as a no-op.
        endcase

        // Anything recognized that is neither a store nor a plain branch writes a register.
        dec.reg_write = known && !dec.mem_write && dec.branch != la32_pkg::BR_BEQ &&
                        dec.branch != la32_pkg::BR_BNE && dec.branch != la32_pkg::BR_B;
        dec.src2_is_imm = (dec.alu_op != la32_pkg::ALU_ADD &&
                           inst[31:15] ==? 17'b000000_0001_00_?????) ||
                          (inst[31:15] ==? 17'b000000_1010_??_?????) ||
                          need_si20 || dec.mem_read || dec.mem_write || src2_is_4;
        dec.src1_is_pc = src2_is_4;  // bl and jirl compute PC+4 in the ALU.
        dec.src2_is_rd = dec.mem_write || dec.branch == la32_pkg::BR_BEQ ||
                         dec.branch == la32_pkg::BR_BNE;

        // The shift amount sits in the low five bits of the si12 field.
        if (src2_is_4) begin
            dec.imm = la32_pkg::word_t'(4);
        end else if (need_si20) begin
            dec.imm = {i20, 12'b0};
        end else begin
            dec.imm = {{20{i12[11]}}, i12};
        end

        dec.br_off = need_si26 ? {{4{i26[25]}}, i26, 2'b00} : {{14{i16[15]}}, i16, 2'b00};

        dec.dest     = (dec.branch == la32_pkg::BR_BL) ? la32_pkg::reg_num_t'(1) : rd;
        dec.rj       = rj;
        dec.rk_or_rd = dec.src2_is_rd ? rd : rk;
    end

endmodule

// ==== src/la32_regfile.sv ====
`timescale 1ns/1ps
`include "la32_macros.svh"

module la32_regfile (
    input  logic               clk,
    input  la32_pkg::reg_num_t raddr1,
    output la32_pkg::word_t    rdata1,
    input  la32_pkg::reg_num_t raddr2,
    output la32_pkg::word_t    rdata2,
    input  logic               we,
    input  la32_pkg::reg_num_t waddr,
    input  la32_pkg::word_t    wdata
);

    la32_pkg::word_t regs [0:`LA32_NUM_REGS-1];

    // Entry zero is never written, so r0 is forced on the read side.
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== src/la32_alu.sv ====
`timescale 1ns/1ps

module la32_alu (
    input  la32_pkg::alu_op_t op,
    input  la32_pkg::word_t   src1,
    input  la32_pkg::word_t   src2,
    output la32_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        result = '0;
        case (op)
            la32_pkg::ALU_ADD: begin
                result = src1 + src2;
            end
            la32_pkg::ALU_SUB: begin
                result = src1 - src2;
            end
            la32_pkg::ALU_SLT: begin
                result[0] = lt_signed;
            end
            la32_pkg::ALU_SLTU: begin
                result[0] = lt_unsigned;
            end
            la32_pkg::ALU_AND: begin
                result = src1 & src2;
            end
            la32_pkg::ALU_NOR: begin
                result = ~(src1 | src2);
            end
            la32_pkg::ALU_OR: begin
                result = src1 | src2;
            end
            la32_pkg::ALU_XOR: begin
                result = src1 ^ src2;
            end
            la32_pkg::ALU_SLL: begin
                result = src1 << shamt;
            end
            la32_pkg::ALU_SRL: begin
                result = src1 >> shamt;
            end
            la32_pkg::ALU_SRA: begin
                result = la32_pkg::word_t'($signed(src1) >>> shamt);  // Sign bit fills.
            end
            la32_pkg::ALU_LUI: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/mycpu_top.sv ====
`timescale 1ns/1ps
`include "la32_macros.svh"

module mycpu_top (
    input  logic               clk,
    input  logic               reset,
    output la32_pkg::word_t    inst_sram_addr,
    input  la32_pkg::word_t    inst_sram_rdata,
    output logic               data_sram_we,
    output la32_pkg::word_t    data_sram_addr,
    output la32_pkg::word_t    data_sram_wdata,
    input  la32_pkg::word_t    data_sram_rdata,
    output la32_pkg::word_t    debug_wb_pc,
    output logic               debug_wb_rf_we,
    output la32_pkg::reg_num_t debug_wb_rf_wnum,
    output la32_pkg::word_t    debug_wb_rf_wdata
);

    la32_pkg::stage_t  state;
    la32_pkg::stage_t  state_next;
    la32_pkg::word_t   pc;
    la32_pkg::word_t   seq_pc;
    la32_pkg::word_t   br_target;
    la32_pkg::word_t   pc_next;
    logic              br_taken;

    la32_pkg::decode_t dec;
    la32_pkg::decode_t dec_r;
    la32_pkg::word_t   rj_value;
    la32_pkg::word_t   rkd_value;
    la32_pkg::word_t   rj_r;
    la32_pkg::word_t   rkd_r;
    la32_pkg::word_t   inst_pc_r;

    la32_pkg::word_t   alu_src1;
    la32_pkg::word_t   alu_src2;
    la32_pkg::word_t   alu_result;
    la32_pkg::word_t   alu_r;
    la32_pkg::word_t   wb_data;

    la32_decoder i_la32_decoder (
        .inst (inst_sram_rdata),
        .dec  (dec)
    );

    la32_regfile i_la32_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .rdata1 (rj_value),
        .raddr2 (dec.rk_or_rd),
        .rdata2 (rkd_value),
        .we     (debug_wb_rf_we),
        .waddr  (dec_r.dest),
        .wdata  (wb_data)
    );

    la32_alu i_la32_alu (
        .op     (dec_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    always_comb begin
        state_next = la32_pkg::FETCH;
        case (state)
            la32_pkg::FETCH: begin
                state_next = la32_pkg::DECODE;
            end
            la32_pkg::DECODE: begin
                if (dec.branch inside {la32_pkg::BR_BEQ, la32_pkg::BR_BNE, la32_pkg::BR_B}) begin
                    state_next = la32_pkg::FETCH;
                end else if (dec.reg_write || dec.mem_read || dec.mem_write) begin
                    state_next = la32_pkg::EXECUTE;
                end
            end
            la32_pkg::EXECUTE: begin
                if (dec_r.mem_read || dec_r.mem_write) begin
                    state_next = la32_pkg::MEMORY;
                end else if (dec_r.reg_write) begin
                    state_next = la32_pkg::WRITEBACK;
                end
            end
            la32_pkg::MEMORY: begin
                if (dec_r.mem_read) begin
                    state_next = la32_pkg::WRITEBACK;
                end
            end
            default: begin
                state_next = la32_pkg::FETCH;
            end
        endcase
    end

    // Branches compare the two register operands read during DECODE.
    always_comb begin
        case (dec.branch)
            la32_pkg::BR_BEQ:  br_taken = (rj_value == rkd_value);
            la32_pkg::BR_BNE:  br_taken = (rj_value != rkd_value);
            la32_pkg::BR_B,
            la32_pkg::BR_BL,
            la32_pkg::BR_JIRL: br_taken = 1'b1;
            default:           br_taken = 1'b0;
        endcase
    end

    assign seq_pc    = pc + la32_pkg::word_t'(4);
    assign br_target = (dec.branch == la32_pkg::BR_JIRL) ? rj_value + dec.br_off
                                                          : pc + dec.br_off;
    assign pc_next   = br_taken ? br_target : seq_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= la32_pkg::FETCH;
            pc    <= `LA32_RESET_PC;
        end else begin
            state <= state_next;
            if (state == la32_pkg::DECODE) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == la32_pkg::DECODE) begin
            dec_r     <= dec;
            rj_r      <= rj_value;
            rkd_r     <= rkd_value;
            inst_pc_r <= pc;
        end
        if (state == la32_pkg::EXECUTE) begin
            alu_r <= alu_result;
        end
    end

    assign alu_src1 = dec_r.src1_is_pc ? inst_pc_r : rj_r;
    assign alu_src2 = dec_r.src2_is_imm ? dec_r.imm : rkd_r;

    assign inst_sram_addr  = pc;  // Stays put until DECODE ends.

    assign data_sram_we    = (state == la32_pkg::MEMORY) && dec_r.mem_write;
    assign data_sram_addr  = alu_r;
    assign data_sram_wdata = rkd_r;

    assign wb_data = dec_r.mem_read ? data_sram_rdata : alu_r;

    assign debug_wb_rf_we    = (state == la32_pkg::WRITEBACK) && dec_r.reg_write;
    assign debug_wb_pc       = inst_pc_r;
    assign debug_wb_rf_wnum  = dec_r.dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// ==== sim/mycpu_properties.sv ====
`timescale 1ns/1ps

module mycpu_properties (
    input logic clk,
    input logic reset,
    input logic data_sram_we,
    input logic debug_wb_rf_we
);

    // A store ends in MEMORY and a write-back happens in WRITEBACK, so they never overlap.
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(data_sram_we && debug_wb_rf_we))
        else $error("data_sram_we and debug_wb_rf_we are high in the same cycle");

    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |=> !debug_wb_rf_we)
        else $error("debug_wb_rf_we is high in two consecutive cycles");

    // The state is only known after the first reset edge.
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !data_sram_we && !debug_wb_rf_we)
        else $error("a strobe is high while reset is held");

endmodule

bind mycpu_top mycpu_properties i_mycpu_properties (
    .clk            (clk),
    .reset          (reset),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);

// ==== sim/tb_mycpu.sv ====
`timescale 1ns/1ps
`include "la32_macros.svh"

module tb_mycpu;

    typedef struct packed {
        la32_pkg::word_t    pc;
        la32_pkg::reg_num_t wnum;
        la32_pkg::word_t    wdata;
    } wb_entry_t;

    typedef struct packed {
        la32_pkg::word_t addr;
        la32_pkg::word_t data;
    } store_entry_t;

    localparam la32_pkg::word_t DONE_ADDR = 32'h0000_07f0;

    logic               clk;
    logic               reset;
    la32_pkg::word_t    inst_sram_addr;
    la32_pkg::word_t    inst_sram_rdata;
    logic               data_sram_we;
    la32_pkg::word_t    data_sram_addr;
    la32_pkg::word_t    data_sram_wdata;
    la32_pkg::word_t    data_sram_rdata;
    la32_pkg::word_t    debug_wb_pc;
    logic               debug_wb_rf_we;
    la32_pkg::reg_num_t debug_wb_rf_wnum;
    la32_pkg::word_t    debug_wb_rf_wdata;

    la32_pkg::word_t imem [0:63];
    la32_pkg::word_t dmem [0:511];
    la32_pkg::word_t fetch_word;
    la32_pkg::word_t load_word;
    wb_entry_t       wb_list [$];
    store_entry_t    store_list [$];
    wb_entry_t       wb_now;
    store_entry_t    store_now;
    int              wb_count;
    int              store_count;
    int              cycles;
    logic            done_seen;

    mycpu_top i_mycpu_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input la32_pkg::word_t want,
                                   input la32_pkg::word_t got);
        fail_run($sformatf("mismatch in %s: expected %h, actual %h", name, want, got));
    endtask

    // Places rd, rj and the field that starts at bit 10 into an opcode base.
    function automatic la32_pkg::word_t encode_inst(input la32_pkg::word_t base, input int rd,
                                                    input int rj, input int field);
        encode_inst = base | (la32_pkg::word_t'(field) << 10) |
                      (la32_pkg::word_t'(rj) << 5) | la32_pkg::word_t'(rd);
    endfunction

    task automatic expect_wb(input int idx, input int wnum, input la32_pkg::word_t wdata);
        wb_list.push_back({`LA32_RESET_PC + la32_pkg::word_t'(idx * 4),
                           la32_pkg::reg_num_t'(wnum), wdata});
    endtask

    task automatic expect_store(input la32_pkg::word_t addr, input la32_pkg::word_t data);
        store_list.push_back({addr, data});
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Both SRAMs register the address on the edge and answer one cycle later.
    always @(posedge clk) begin
        fetch_word = imem[inst_sram_addr[7:2]];
        load_word  = dmem[data_sram_addr[10:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[10:2]] = data_sram_wdata;
        end
        #1;
        inst_sram_rdata = fetch_word;
        data_sram_rdata = load_word;
    end

    always @(negedge clk) begin
        if (!reset && debug_wb_rf_we) begin
            if (wb_count >= wb_list.size()) begin
                fail_run("a register write-back was traced after the last expected one");
            end else begin
                wb_now = wb_list[wb_count];
                assert (debug_wb_pc == wb_now.pc)
                    else report_mismatch($sformatf("write-back %0d pc", wb_count),
                                         wb_now.pc, debug_wb_pc);
                assert (debug_wb_rf_wnum == wb_now.wnum)
                    else report_mismatch($sformatf("write-back %0d wnum", wb_count),
                                         la32_pkg::word_t'(wb_now.wnum),
                                         la32_pkg::word_t'(debug_wb_rf_wnum));
                assert (debug_wb_rf_wdata == wb_now.wdata)
                    else report_mismatch($sformatf("write-back %0d wdata", wb_count),
                                         wb_now.wdata, debug_wb_rf_wdata);
                wb_count++;
            end
        end
        if (!reset && data_sram_we) begin
            if (store_count >= store_list.size()) begin
                fail_run("a store was seen after the last expected one");
            end else begin
                store_now = store_list[store_count];
                assert (data_sram_addr == store_now.addr)
                    else report_mismatch($sformatf("store %0d addr", store_count),
                                         store_now.addr, data_sram_addr);
                assert (data_sram_wdata == store_now.data)
                    else report_mismatch($sformatf("store %0d data", store_count),
                                         store_now.data, data_sram_wdata);
                store_count++;
                done_seen = (data_sram_addr == DONE_ADDR);
            end
        end
    end

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        wb_count        = 0;
        store_count     = 0;
        done_seen       = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (`LA32_RESET_PC + la32_pkg::word_t'(i * 4)) ^ 32'hfc00_0000;
        end
        for (int i = 0; i < 512; i++) begin
            dmem[i] = la32_pkg::word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        imem[0]  = encode_inst(32'h0280_0000, 2, 0, 'hff8);   // addi.w r2, r0, -8
        imem[1]  = encode_inst(32'h0280_0000, 3, 0, 5);       // addi.w r3, r0, 5
        imem[2]  = 32'h1424_68a4;                             // lu12i.w r4, 0x12345
        imem[3]  = encode_inst(32'h0010_0000, 5, 2, 3);       // add.w r5, r2, r3
        imem[4]  = encode_inst(32'h0011_0000, 6, 3, 2);       // sub.w r6, r3, r2
        imem[5]  = encode_inst(32'h0012_0000, 7, 2, 3);       // slt r7, r2, r3
        imem[6]  = encode_inst(32'h0012_8000, 8, 2, 3);       // sltu r8, r2, r3
        imem[7]  = encode_inst(32'h0014_8000, 9, 4, 2);       // and r9, r4, r2
        imem[8]  = encode_inst(32'h0015_0000, 10, 4, 3);      // or r10, r4, r3
        imem[9]  = encode_inst(32'h0015_8000, 11, 4, 2);      // xor r11, r4, r2
        imem[10] = encode_inst(32'h0014_0000, 12, 4, 3);      // nor r12, r4, r3
        imem[11] = encode_inst(32'h0040_8000, 13, 3, 4);      // slli.w r13, r3, 4
        imem[12] = encode_inst(32'h0044_8000, 14, 2, 4);      // srli.w r14, r2, 4
        imem[13] = encode_inst(32'h0048_8000, 15, 2, 2);      // srai.w r15, r2, 2
        imem[14] = encode_inst(32'h0280_0000, 0, 0, 99);      // addi.w r0, r0, 99
        imem[15] = encode_inst(32'h0010_0000, 16, 0, 3);      // add.w r16, r0, r3
        imem[16] = encode_inst(32'h0280_0000, 20, 0, 'h100);  // addi.w r20, r0, 0x100
        imem[17] = encode_inst(32'h2980_0000, 4, 20, 8);      // st.w r4, r20, 8
        imem[18] = encode_inst(32'h2880_0000, 17, 20, 8);     // ld.w r17, r20, 8
        imem[19] = encode_inst(32'h5800_0000, 16, 3, 2);      // beq r3, r16, +8
        imem[20] = encode_inst(32'h0280_0000, 18, 0, 1);      // Skipped by the beq.
        imem[21] = encode_inst(32'h5c00_0000, 16, 3, 2);      // bne r3, r16, +8
        imem[22] = encode_inst(32'h0280_0000, 19, 0, 7);      // addi.w r19, r0, 7
        imem[23] = encode_inst(32'h5400_0000, 0, 0, 2);       // bl +8
        imem[24] = encode_inst(32'h5000_0000, 0, 0, 3);       // b +12
        imem[25] = encode_inst(32'h0280_0000, 21, 0, 'h21);   // addi.w r21, r0, 0x21
        imem[26] = encode_inst(32'h4c00_0000, 0, 1, 0);       // jirl r0, r1, 0
        imem[27] = encode_inst(32'h0010_0000, 22, 5, 17);     // add.w r22, r5, r17
        imem[28] = encode_inst(32'h0010_0000, 22, 22, 19);    // add.w r22, r22, r19
        imem[29] = encode_inst(32'h0010_0000, 22, 22, 21);    // add.w r22, r22, r21
        imem[30] = encode_inst(32'h2980_0000, 22, 0, 'h7f0);  // st.w r22, r0, 0x7f0
        imem[31] = encode_inst(32'h5000_0000, 0, 0, 0);       // b 0, parks the core.

        expect_wb(0, 2, 32'hffff_fff8);
        expect_wb(1, 3, 32'h0000_0005);
        expect_wb(2, 4, 32'h1234_5000);
        expect_wb(3, 5, 32'hffff_fffd);
        expect_wb(4, 6, 32'h0000_000d);
        expect_wb(5, 7, 32'h0000_0001);  // Signed compare of -8 and 5.
        expect_wb(6, 8, 32'h0000_0000);
        expect_wb(7, 9, 32'h1234_5000);
        expect_wb(8, 10, 32'h1234_5005);
        expect_wb(9, 11, 32'hedcb_aff8);
        expect_wb(10, 12, 32'hedcb_affa);
        expect_wb(11, 13, 32'h0000_0050);
        expect_wb(12, 14, 32'h0fff_ffff);
        expect_wb(13, 15, 32'hffff_fffe);
        expect_wb(14, 0, 32'h0000_0063);
        expect_wb(15, 16, 32'h0000_0005);
        expect_wb(16, 20, 32'h0000_0100);
        expect_wb(18, 17, 32'h1234_5000);
        expect_wb(22, 19, 32'h0000_0007);
        expect_wb(23, 1, 32'h1c00_0060);
        expect_wb(25, 21, 32'h0000_0021);
        expect_wb(26, 0, 32'h1c00_006c);
        expect_wb(27, 22, 32'h1234_4ffd);
        expect_wb(28, 22, 32'h1234_5004);
        expect_wb(29, 22, 32'h1234_5025);
        expect_store(32'h0000_0108, 32'h1234_5000);
        // Checksum of the add.w, ld.w, bne fall-through and subroutine results.
        expect_store(DONE_ADDR, 32'hffff_fffd + 32'h1234_5000 + 32'h0000_0007 + 32'h0000_0021);

        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (!done_seen && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            fail_run("timeout: no store to the done address within 2000 cycles");
        end else if (wb_count != wb_list.size()) begin
            fail_run($sformatf("only %0d of %0d write-backs were traced",
                               wb_count, wb_list.size()));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/la32_pkg.sv
src/la32_decoder.sv
src/la32_regfile.sv
src/la32_alu.sv
src/mycpu_top.sv
sim/mycpu_properties.sv
sim/tb_mycpu.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mycpu -f verilog.f -Mdir obj_dir -o sim_tb_mycpu

run: compile
	./obj_dir/sim_tb_mycpu 2>&1 | tee run.log
	grep -q "SIMULATION PASSED" run.log

clean:
	rm -rf obj_dir run.log
